// File: rtl/mem_pkg.sv
package mem_pkg;

  // Bank select on the host bus
  typedef enum logic [1:0] {
    SEL_CONTROLLER = 2'd0,
    SEL_MOD        = 2'd1,
    SEL_DUTY       = 2'd2,
    SEL_STM        = 2'd3
  } bram_sel_t;

  // Host bus widths
  localparam int ADDR_W = 14;
  localparam int DATA_W = 16;

  // Per-bank address and word widths
  localparam int CTL_AW  = 8;
  localparam int MOD_AW  = 9;
  localparam int DUTY_AW = 9;
  localparam int DUTY_W  = 8;
  localparam int STM_AW  = 12;

  // Configuration words inside the controller bank
  localparam logic [CTL_AW-1:0] ADDR_MOD_WR_SEGMENT = 8'h20;
  localparam logic [CTL_AW-1:0] ADDR_STM_WR_SEGMENT = 8'h21;
  localparam logic [CTL_AW-1:0] ADDR_STM_WR_PAGE    = 8'h22;
  localparam logic [CTL_AW-1:0] ADDR_DUTY_WR_PAGE   = 8'h23;

  // Segment view of a config word
  typedef struct packed {
    logic [DATA_W-2:0] rsvd;
    logic              segment;
  } cfg_seg_t;

  // Page view of a config word
  typedef struct packed {
    logic [DATA_W-5:0] rsvd;
    logic [3:0]        page;
  } cfg_page_t;

  // Same host word, read two ways depending on the config address
  typedef union packed {
    cfg_seg_t  seg;
    cfg_page_t pg;
  } cfg_word_u;

endpackage

// File: rtl/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if
  import mem_pkg::*;
();

  logic              en;
  logic              we;
  bram_sel_t         select;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data_in;
  logic [DATA_W-1:0] data_out;

  // Host drives the strobes, address and write data
  modport host (
    output en, we, select, addr, data_in,
    input  data_out
  );

  modport bank (
    input  en, we, select, addr, data_in,
    output data_out
  );

endinterface

// File: rtl/ctl_port_if.sv
`timescale 1ns/1ps

interface ctl_port_if
  import mem_pkg::*;
();

  logic              we;
  logic [CTL_AW-1:0] addr;
  logic [DATA_W-1:0] din;
  logic [DATA_W-1:0] dout;

  modport host (
    output we, addr, din,
    input  dout
  );

  // Controller bank side returns read data
  modport bank (
    input  we, addr, din,
    output dout
  );

endinterface

// File: rtl/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram #(
  parameter int AW = 8,
  parameter int DW = 16
) (
  input  logic          bus_clk,
  input  logic          a_en,
  input  logic          a_we,
  input  logic [AW-1:0] a_addr,
  input  logic [DW-1:0] a_din,
  output logic [DW-1:0] a_dout,
  input  logic          b_en,
  input  logic          b_we,
  input  logic [AW-1:0] b_addr,
  input  logic [DW-1:0] b_din,
  output logic [DW-1:0] b_dout
);

  logic [DW-1:0] mem [2**AW];

  // Read-first on both ports so a write returns the old word
  always_ff @(posedge bus_clk) begin
    if (a_en) begin
      if (a_we) mem[a_addr] <= a_din;
      a_dout <= mem[a_addr];
    end
    if (b_en) begin
      if (b_we) mem[b_addr] <= b_din;
      b_dout <= mem[b_addr];
    end
  end

  a_addr_known: assert property (@(posedge bus_clk) a_en |-> !$isunknown(a_addr))
    else $error("port A address unknown while enabled");

  b_addr_known: assert property (@(posedge bus_clk) b_en |-> !$isunknown(b_addr))
    else $error("port B address unknown while enabled");

endmodule

// File: rtl/memory_map.sv
`timescale 1ns/1ps

module memory_map
  import mem_pkg::*;
(
  input  logic               bus_clk,
  input  logic               rst_n,
  mem_bus_if.bank            bus,
  ctl_port_if.bank           ctl,
  input  logic [MOD_AW-1:0]  mod_idx,
  input  logic               mod_segment,
  output logic [DATA_W-1:0]  mod_value,
  input  logic [STM_AW-1:0]  stm_addr,
  input  logic               stm_segment,
  output logic [DATA_W-1:0]  stm_value,
  input  logic [DUTY_AW-1:0] duty_idx,
  output logic [DUTY_W-1:0]  duty_value
);

  logic ctl_en;
  logic mod_en;
  logic duty_en;
  logic stm_en;

  // Write-side config registers
  logic       mod_wr_segment;
  logic       stm_wr_segment;
  logic [3:0] stm_wr_page;
  logic       duty_wr_page;

  logic              cfg_pend;
  logic [CTL_AW-1:0] cfg_addr_q;
  cfg_word_u         cfg_word_q;

  logic [1:0]        mod_seg_en;
  logic [1:0]        stm_seg_en;
  logic [DATA_W-1:0] mod_dout [2];
  logic [DATA_W-1:0] stm_dout [2];
  logic              mod_rd_seg_q;
  logic              stm_rd_seg_q;

  // Bank decode
  assign ctl_en  = bus.en && (bus.select == SEL_CONTROLLER);
  assign mod_en  = bus.en && (bus.select == SEL_MOD);
  assign duty_en = bus.en && (bus.select == SEL_DUTY);
  assign stm_en  = bus.en && (bus.select == SEL_STM);

  // Only the segment picked by the write register sees the host write
  assign mod_seg_en = {mod_en && mod_wr_segment, mod_en && !mod_wr_segment};
  assign stm_seg_en = {stm_en && stm_wr_segment, stm_en && !stm_wr_segment};

  dual_port_ram #(.AW(CTL_AW), .DW(DATA_W)) u_ctl_ram (
    .bus_clk (bus_clk),
    .a_en    (ctl_en),
    .a_we    (bus.we),
    .a_addr  (bus.addr[CTL_AW-1:0]),
    .a_din   (bus.data_in),
    .a_dout  (bus.data_out),
    .b_en    (1'b1),
    .b_we    (ctl.we),
    .b_addr  (ctl.addr),
    .b_din   (ctl.din),
    .b_dout  (ctl.dout)
  );

  // Duty table with its page bit above the low host address
  dual_port_ram #(.AW(DUTY_AW), .DW(DUTY_W)) u_duty_ram (
    .bus_clk (bus_clk),
    .a_en    (duty_en),
    .a_we    (bus.we),
    .a_addr  ({duty_wr_page, bus.addr[7:0]}),
    .a_din   (bus.data_in[DUTY_W-1:0]),
    .a_dout  (),
    .b_en    (1'b1),
    .b_we    (1'b0),
    .b_addr  (duty_idx),
    .b_din   ('0),
    .b_dout  (duty_value)
  );

  for (genvar s = 0; s < 2; s++) begin : g_seg
    dual_port_ram #(.AW(MOD_AW), .DW(DATA_W)) u_mod_ram (
      .bus_clk (bus_clk),
      .a_en    (mod_seg_en[s]),
      .a_we    (bus.we),
      .a_addr  (bus.addr[MOD_AW-1:0]),
      .a_din   (bus.data_in),
      .a_dout  (),
      .b_en    (1'b1),
      .b_we    (1'b0),
      .b_addr  (mod_idx),
      .b_din   ('0),
      .b_dout  (mod_dout[s])
    );

    dual_port_ram #(.AW(STM_AW), .DW(DATA_W)) u_stm_ram (
      .bus_clk (bus_clk),
      .a_en    (stm_seg_en[s]),
      .a_we    (bus.we),
      .a_addr  ({stm_wr_page, bus.addr[7:0]}),
      .a_din   (bus.data_in),
      .a_dout  (),
      .b_en    (1'b1),
      .b_we    (1'b0),
      .b_addr  (stm_addr),
      .b_din   ('0),
      .b_dout  (stm_dout[s])
    );
  end

  // Segment follows its address through the RAM latency
  always_ff @(posedge bus_clk) begin
    mod_rd_seg_q <= mod_segment;
    stm_rd_seg_q <= stm_segment;
  end

  assign mod_value = mod_rd_seg_q ? mod_dout[1] : mod_dout[0];
  assign stm_value = stm_rd_seg_q ? stm_dout[1] : stm_dout[0];

  // Capture a controller-bank host write and apply it one edge later
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      cfg_pend <= 1'b0;
    end else begin
      cfg_pend <= ctl_en && bus.we;
    end
  end

  always_ff @(posedge bus_clk) begin
    cfg_addr_q <= bus.addr[CTL_AW-1:0];
    cfg_word_q <= bus.data_in;
  end

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      mod_wr_segment <= 1'b0;
      stm_wr_segment <= 1'b0;
      stm_wr_page    <= 4'd0;
      duty_wr_page   <= 1'b0;
    end else if (cfg_pend) begin
      case (cfg_addr_q)
        ADDR_MOD_WR_SEGMENT: mod_wr_segment <= cfg_word_q.seg.segment;
        ADDR_STM_WR_SEGMENT: stm_wr_segment <= cfg_word_q.seg.segment;
        ADDR_STM_WR_PAGE:    stm_wr_page    <= cfg_word_q.pg.page;
        // Duty table has a single page bit
        ADDR_DUTY_WR_PAGE:   duty_wr_page   <= cfg_word_q.pg.page[0];
        default: ;
      endcase
    end
  end

  wr_select_known: assert property (
    @(posedge bus_clk) disable iff (!rst_n)
    (bus.en && bus.we) |-> !$isunknown(bus.select)
  ) else $error("host write with unknown bank select");

  cfg_regs_known: assert property (
    @(posedge bus_clk) disable iff (!rst_n)
    !$isunknown({mod_wr_segment, stm_wr_segment, stm_wr_page, duty_wr_page})
  ) else $error("write-side config register unknown after reset");

endmodule

// File: rtl/mem_top.sv
`timescale 1ns/1ps

module mem_top
  import mem_pkg::*;
(
  input  logic               bus_clk,
  input  logic               rst_n,
  input  logic               en,
  input  logic               we,
  input  bram_sel_t          select,
  input  logic [ADDR_W-1:0]  addr,
  input  logic [DATA_W-1:0]  data_in,
  output logic [DATA_W-1:0]  data_out,
  input  logic               ctl_we,
  input  logic [CTL_AW-1:0]  ctl_addr,
  input  logic [DATA_W-1:0]  ctl_din,
  output logic [DATA_W-1:0]  ctl_dout,
  input  logic [MOD_AW-1:0]  mod_idx,
  input  logic               mod_segment,
  output logic [DATA_W-1:0]  mod_value,
  input  logic [STM_AW-1:0]  stm_addr,
  input  logic               stm_segment,
  output logic [DATA_W-1:0]  stm_value,
  input  logic [DUTY_AW-1:0] duty_idx,
  output logic [DUTY_W-1:0]  duty_value
);

  mem_bus_if  bus ();
  ctl_port_if ctl ();

  // Host side of the memory bus
  assign bus.en      = en;
  assign bus.we      = we;
  assign bus.select  = select;
  assign bus.addr    = addr;
  assign bus.data_in = data_in;
  assign data_out    = bus.data_out;

  // Controller port
  assign ctl.we   = ctl_we;
  assign ctl.addr = ctl_addr;
  assign ctl.din  = ctl_din;
  assign ctl_dout = ctl.dout;

  memory_map u_memory_map (
    .bus_clk     (bus_clk),
    .rst_n       (rst_n),
    .bus         (bus.bank),
    .ctl         (ctl.bank),
    .mod_idx     (mod_idx),
    .mod_segment (mod_segment),
    .mod_value   (mod_value),
    .stm_addr    (stm_addr),
    .stm_segment (stm_segment),
    .stm_value   (stm_value),
    .duty_idx    (duty_idx),
    .duty_value  (duty_value)
  );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD = 4.0
) (
  output logic bus_clk
);

  initial bus_clk = 1'b0;

  always #(PERIOD / 2) bus_clk = ~bus_clk;

endmodule

// File: tests/tb_mem_top.sv
`timescale 1ns/1ps

module tb_mem_top
  import mem_pkg::*;
();

  localparam int RESET_TIMEOUT = 20;
  localparam int TRACE_TIMEOUT = 2000;

  logic               bus_clk;
  logic               rst_n;
  logic               en;
  logic               we;
  bram_sel_t          select;
  logic [ADDR_W-1:0]  addr;
  logic [DATA_W-1:0]  data_in;
  logic [DATA_W-1:0]  data_out;
  logic               ctl_we;
  logic [CTL_AW-1:0]  ctl_addr;
  logic [DATA_W-1:0]  ctl_din;
  logic [DATA_W-1:0]  ctl_dout;
  logic [MOD_AW-1:0]  mod_idx;
  logic               mod_segment;
  logic [DATA_W-1:0]  mod_value;
  logic [STM_AW-1:0]  stm_addr;
  logic               stm_segment;
  logic [DATA_W-1:0]  stm_value;
  logic [DUTY_AW-1:0] duty_idx;
  logic [DUTY_W-1:0]  duty_value;

  int errors = 0;
  int test_errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_passed = 0;
  int cycles = 0;
  bit timed_out = 1'b0;

  tb_clock_gen #(.PERIOD(4.0)) u_clock_gen (.bus_clk(bus_clk));

  mem_top u_mem_top (.*);

  always @(posedge bus_clk) cycles <= cycles + 1;

  // Idle values and reset held low for two edges
  initial begin
    rst_n = 1'b0;
    en = 1'b0;
    we = 1'b0;
    select = SEL_CONTROLLER;
    addr = '0;
    data_in = '0;
    ctl_we = 1'b0;
    ctl_addr = '0;
    ctl_din = '0;
    mod_idx = '0;
    mod_segment = 1'b0;
    stm_addr = '0;
    stm_segment = 1'b0;
    duty_idx = '0;
    repeat (2) @(posedge bus_clk);
    rst_n <= 1'b1;
  end

  task automatic compare_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
      errors++;
      test_errors++;
    end
  endtask

  task automatic host_write(input logic [1:0] sel, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d);
    @(posedge bus_clk);
    en <= 1'b1;
    we <= 1'b1;
    select <= bram_sel_t'(sel);
    addr <= a;
    data_in <= d;
    @(posedge bus_clk);
    en <= 1'b0;
    we <= 1'b0;
  endtask

  // Controller bank read with data one cycle after the strobe
  task automatic host_read(input logic [15:0] a, input logic [15:0] exp);
    @(posedge bus_clk);
    en <= 1'b1;
    we <= 1'b0;
    select <= SEL_CONTROLLER;
    addr <= a[ADDR_W-1:0];
    @(posedge bus_clk);
    en <= 1'b0;
    @(negedge bus_clk);
    compare_value("data_out", data_out, exp);
  endtask

  task automatic ctl_write(input logic [15:0] a, input logic [15:0] d);
    @(posedge bus_clk);
    ctl_we <= 1'b1;
    ctl_addr <= a[CTL_AW-1:0];
    ctl_din <= d;
    @(posedge bus_clk);
    ctl_we <= 1'b0;
  endtask

  task automatic ctl_read(input logic [15:0] a, input logic [15:0] exp);
    @(posedge bus_clk);
    ctl_addr <= a[CTL_AW-1:0];
    @(posedge bus_clk);
    @(negedge bus_clk);
    compare_value("ctl_dout", ctl_dout, exp);
  endtask

  // Modulation, STM or duty read port
  task automatic consumer_read(input logic [7:0] op, input logic seg,
                               input logic [15:0] a, input logic [15:0] exp);
    @(posedge bus_clk);
    mod_segment <= seg;
    stm_segment <= seg;
    if (op == "M") mod_idx <= a[MOD_AW-1:0];
    if (op == "S") stm_addr <= a[STM_AW-1:0];
    if (op == "D") duty_idx <= a[DUTY_AW-1:0];
    @(posedge bus_clk);
    // Inputs move on, the value must still belong to the request above
    mod_segment <= ~seg;
    stm_segment <= ~seg;
    mod_idx <= ~a[MOD_AW-1:0];
    stm_addr <= ~a[STM_AW-1:0];
    duty_idx <= ~a[DUTY_AW-1:0];
    @(negedge bus_clk);
    case (op)
      "M": compare_value("mod_value", mod_value, exp);
      "S": compare_value("stm_value", stm_value, exp);
      default: compare_value("duty_value", {8'h00, duty_value}, exp);
    endcase
  endtask

  task automatic end_test(input logic [15:0] id);
    tests_run++;
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d: pass", id);
    end else begin
      $display("test %0d: %0d mismatches", id, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    int fd;
    int n;
    int start;
    logic [7:0] op;
    logic [15:0] f1;
    logic [15:0] f2;
    logic [15:0] f3;
    logic [8*80-1:0] rest;
    start = 0;
    while (rst_n !== 1'b1 && start < RESET_TIMEOUT) begin
      @(posedge bus_clk);
      start++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
      timed_out = 1'b1;
    end
    fd = $fopen("tests/mem_trace.txt", "r");
    if (fd == 0) begin
      $display("Error: could not open the trace file tests/mem_trace.txt");
      errors++;
    end
    start = cycles;
    while (fd != 0 && !timed_out && $fscanf(fd, " %c", op) == 1) begin
      if (cycles - start > TRACE_TIMEOUT) begin
        $display("Timeout: trace did not finish within %0d cycles", TRACE_TIMEOUT);
        timed_out = 1'b1;
      end else if (op == "#") begin
        n = $fgets(rest, fd);
      end else begin
        // Two-operand lines keep address and value in f2 and f3
        case (op)
          "W", "M", "S": n = $fscanf(fd, " %h %h %h", f1, f2, f3);
          "T": n = $fscanf(fd, " %h", f1);
          default: n = $fscanf(fd, " %h %h", f2, f3);
        endcase
        case (op)
          "W": host_write(f1[1:0], f2[ADDR_W-1:0], f3);
          "R": host_read(f2, f3);
          "C": ctl_write(f2, f3);
          "K": ctl_read(f2, f3);
          "M", "S", "D": consumer_read(op, f1[0], f2, f3);
          "T": end_test(f1);
          default: begin
            $display("Error: unknown trace opcode '%c'", op);
            errors++;
          end
        endcase
      end
    end
    if (fd != 0) $fclose(fd);
    $display("%0d of %0d tests passed, %0d checks, %0d errors",
             tests_passed, tests_run, checks, errors);
    if (errors == 0 && !timed_out && tests_run > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: tests/mem_trace.txt
# op and hex operands: W sel addr data | R addr exp | C addr data | K addr exp
# M seg idx exp | S seg addr exp | D idx exp | T test_id
# Controller bank round trip
W 0 0010 1234
R 0010 1234
C 05 abcd
R 0005 abcd
W 0 0030 5a5a
K 30 5a5a
T 1
# Modulation segments
W 1 0000 1111
W 1 01ff 2222
W 0 0020 0001
W 1 0000 aaaa
W 1 01ff bbbb
M 0 000 1111
M 1 000 aaaa
M 1 1ff bbbb
T 2
# STM pages and segments
W 3 0010 0100
W 0 0022 0005
W 3 0010 0510
W 0 0021 0001
W 3 0010 1510
S 0 010 0100
S 0 510 0510
S 1 510 1510
T 3
# Duty-table pages, low byte kept
W 2 0040 12a5
W 0 0023 0001
W 2 0040 3c7e
D 040 00a5
D 140 007e
T 4
# Config word is stored and still steers STM writes
W 0 0022 0003
R 0022 0003
W 3 0020 beef
S 1 320 beef
T 5

// File: vlog.f
rtl/mem_pkg.sv
rtl/mem_bus_if.sv
rtl/ctl_port_if.sv
rtl/dual_port_ram.sv
rtl/memory_map.sv
rtl/mem_top.sv
tests/tb_clock_gen.sv
tests/tb_mem_top.sv

// File: Bender.yml
package:
  name: mem_top

sources:
  - rtl/mem_pkg.sv
  - rtl/mem_bus_if.sv
  - rtl/ctl_port_if.sv
  - rtl/dual_port_ram.sv
  - rtl/memory_map.sv
  - rtl/mem_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_mem_top.sv
